// File: verilog/cpu_pkg.sv
package cpu_pkg;

	localparam int DATA_W    = 16;
	localparam int INSTR_W   = 16;
	localparam int REG_IDX_W = 4;
	localparam int OPCODE_W  = 4;
	localparam int FUNC_W    = 4;

	typedef logic [DATA_W-1:0]    data_t;
	typedef logic [INSTR_W-1:0]   instr_t;
	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	// Instruction layout is opcode | ra | rb | func or imm4
	typedef enum logic [OPCODE_W-1:0] {
		ARITHM = 4'd0,
		LW     = 4'd1,
		SW     = 4'd2,
		BLT    = 4'd3,
		BGT    = 4'd4,
		BE     = 4'd5,
		JMP    = 4'd6,
		HALT   = 4'd7
	} opcode_t;

	// Function field of ARITHM instructions
	typedef enum logic [FUNC_W-1:0] {
		ADD = 4'd0,
		SUB = 4'd1,
		AND = 4'd2,
		OR  = 4'd3,
		XOR = 4'd4,
		MUL = 4'd5,
		DIV = 4'd6,
		ROR = 4'd7,
		ROL = 4'd8,
		SHL = 4'd9,
		SHR = 4'd10
	} control_e;

	// Core status as seen at the top level
	typedef enum logic [1:0] {
		RUNNING   = 2'd0,
		HALTED    = 2'd1,
		EXCEPTION = 2'd2
	} halt_reason_e;

	// Operand B and pc offset selection
	localparam logic [1:0] SEL_REG   = 2'b00;
	localparam logic [1:0] SEL_IMM_B = 2'b01;
	localparam logic [1:0] SEL_IMM4  = 2'b10;
	localparam logic [1:0] SEL_JMP   = 2'b11;

endpackage

// File: verilog/ctrl_if.sv
`timescale 1ns/1ps

interface ctrl_if;

	logic       alu_op;
	logic [1:0] offset_sel;
	logic       mem2r;
	logic       memwr;
	logic       halt_sys;
	logic       reg_wr;
	logic       r0_read;
	logic       se_imm_a;

	modport decoder (
		output alu_op,
		output offset_sel,
		output mem2r,
		output memwr,
		output halt_sys,
		output reg_wr,
		output r0_read,
		output se_imm_a
	);

	modport datapath (
		input alu_op,
		input offset_sel,
		input mem2r,
		input memwr,
		input halt_sys,
		input reg_wr,
		input r0_read,
		input se_imm_a
	);

endinterface

// File: verilog/control_main.sv
`timescale 1ns/1ps

module control_main (
	input  cpu_pkg::opcode_t  opcode,
	input  cpu_pkg::control_e func,
	input  logic              div0,
	input  logic              overflow,
	ctrl_if.decoder           ctl
);

	import cpu_pkg::*;

	logic dec_mem2r;
	logic dec_memwr;
	logic dec_halt;
	logic dec_reg_wr;

	// Operand steering depends on the instruction only, never on the alu flags
	always_comb begin
		ctl.alu_op     = 1'b0;
		ctl.offset_sel = SEL_REG;
		ctl.r0_read    = 1'b0;
		ctl.se_imm_a   = 1'b0;
		dec_mem2r      = 1'b0;
		dec_memwr      = 1'b0;
		dec_halt       = 1'b0;
		dec_reg_wr     = 1'b0;

		case (opcode)
			ARITHM: begin
				if ((func == ROR) || (func == ROL) || (func == SHL) || (func == SHR))
					ctl.offset_sel = SEL_IMM_B;
				else
					ctl.offset_sel = SEL_REG;
				ctl.se_imm_a = 1'b1;
				dec_reg_wr   = 1'b1;
			end
			LW: begin
				ctl.alu_op     = 1'b1;
				ctl.offset_sel = SEL_IMM4;
				dec_mem2r      = 1'b1;
				dec_reg_wr     = 1'b1;
			end
			SW: begin
				ctl.alu_op     = 1'b1;
				ctl.offset_sel = SEL_IMM4;
				dec_memwr      = 1'b1;
			end
			BLT: begin
				ctl.offset_sel = SEL_IMM4;
				ctl.r0_read    = 1'b1;
				ctl.se_imm_a   = 1'b1;
			end
			BGT: begin
				ctl.offset_sel = SEL_IMM4;
				ctl.r0_read    = 1'b1;
				ctl.se_imm_a   = 1'b1;
			end
			BE: begin
				ctl.offset_sel = SEL_IMM4;
				ctl.r0_read    = 1'b1;
				ctl.se_imm_a   = 1'b1;
			end
			JMP: begin
				ctl.offset_sel = SEL_JMP;
				ctl.se_imm_a   = 1'b1;
			end
			HALT: begin
				ctl.se_imm_a = 1'b1;
				dec_halt     = 1'b1;
			end
			// Illegal opcode
			default: begin
				dec_halt = 1'b1;
			end
		endcase
	end

	// An arithmetic exception stops the core with all writes blocked
	always_comb begin
		if (div0 || overflow) begin
			ctl.mem2r    = 1'b0;
			ctl.memwr    = 1'b0;
			ctl.halt_sys = 1'b1;
			ctl.reg_wr   = 1'b0;
		end else begin
			ctl.mem2r    = dec_mem2r;
			ctl.memwr    = dec_memwr;
			ctl.halt_sys = dec_halt;
			ctl.reg_wr   = dec_reg_wr;
		end
	end

endmodule

// File: verilog/alu.sv
`timescale 1ns/1ps

module alu (
	input  cpu_pkg::data_t    a,
	input  cpu_pkg::data_t    b,
	input  cpu_pkg::control_e func,
	input  logic              force_add,
	output cpu_pkg::data_t    result,
	output logic              div0,
	output logic              overflow
);

	import cpu_pkg::*;

	control_e            op;
	logic [3:0]          sh;
	data_t               sum;
	data_t               diff;
	logic [2*DATA_W-1:0] dbl;
	logic [2*DATA_W-1:0] rot_r;
	logic [2*DATA_W-1:0] rot_l;

	assign op = force_add ? ADD : func;
	assign sh = b[3:0];

	assign sum  = a + b;
	assign diff = a - b;

	// Rotates come from shifting a doubled copy of a
	assign dbl   = {a, a};
	assign rot_r = dbl >> sh;
	assign rot_l = dbl << sh;

	always_comb begin
		case (op)
			ADD:     result = sum;
			SUB:     result = diff;
			AND:     result = a & b;
			OR:      result = a | b;
			XOR:     result = a ^ b;
			MUL:     result = a * b;
			DIV:     result = (b == '0) ? '1 : a / b;
			ROR:     result = rot_r[DATA_W-1:0];
			ROL:     result = rot_l[2*DATA_W-1:DATA_W];
			SHL:     result = a << sh;
			SHR:     result = a >> sh;
			default: result = '0;
		endcase
	end

	always_comb begin
		overflow = 1'b0;
		div0     = 1'b0;
		if (!force_add) begin
			case (func)
				ADD: overflow = (a[DATA_W-1] == b[DATA_W-1]) &&
				                (sum[DATA_W-1] != a[DATA_W-1]);
				SUB: overflow = (a[DATA_W-1] != b[DATA_W-1]) &&
				                (diff[DATA_W-1] != a[DATA_W-1]);
				DIV: div0 = (b == '0);
				default: begin
					overflow = 1'b0;
					div0     = 1'b0;
				end
			endcase
		end
	end

endmodule

// File: verilog/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic               clk,
	input  logic               rst,
	input  cpu_pkg::reg_idx_t  ra_idx,
	input  cpu_pkg::reg_idx_t  rb_idx,
	output cpu_pkg::data_t     ra_data,
	output cpu_pkg::data_t     rb_data,
	output cpu_pkg::data_t     r0_data,
	input  logic               we,
	input  cpu_pkg::reg_idx_t  wr_idx,
	input  cpu_pkg::data_t     wr_data
);

	import cpu_pkg::*;

	localparam int NUM_REGS = 2 ** REG_IDX_W;

	data_t regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (we) begin
			regs[wr_idx] <= wr_data;
		end
	end

	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];
	// Branch compares always look at register zero
	assign r0_data = regs[0];

endmodule

// File: verilog/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
	parameter int IMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          run,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  cpu_pkg::instr_t               imem_wdata,
	input  logic                          take_branch,
	ctrl_if.datapath                      ctl,
	input  logic                          exception,
	output cpu_pkg::instr_t               instr,
	output logic [$clog2(IMEM_DEPTH)-1:0] pc,
	output cpu_pkg::halt_reason_e         status
);

	import cpu_pkg::*;

	localparam int PC_W = $clog2(IMEM_DEPTH);

	instr_t          imem [IMEM_DEPTH];
	logic [PC_W-1:0] br_off;
	logic [PC_W-1:0] jmp_off;
	logic [PC_W-1:0] next_pc;

	// Program load only while the core is stopped
	always_ff @(posedge clk) begin
		if (imem_we && !run)
			imem[imem_addr] <= imem_wdata;
	end

	assign instr = imem[pc];

	assign br_off  = PC_W'($signed(instr[7:0]));
	assign jmp_off = PC_W'($signed(instr[11:0]));

	always_comb begin
		if (ctl.offset_sel == SEL_JMP)
			next_pc = pc + jmp_off;
		else if (take_branch)
			next_pc = pc + br_off;
		else
			next_pc = pc + 1'b1;
	end

	// pc stays on the instruction that stopped the core
	always_ff @(posedge clk) begin
		if (rst) begin
			pc     <= '0;
			status <= RUNNING;
		end else if (run && status == RUNNING) begin
			if (ctl.halt_sys)
				status <= exception ? EXCEPTION : HALTED;
			else
				pc <= next_pc;
		end
	end

endmodule

// File: verilog/data_mem.sv
`timescale 1ns/1ps

module data_mem #(
	parameter int DMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          run,
	ctrl_if.datapath                      ctl,
	input  cpu_pkg::data_t                core_addr,
	input  cpu_pkg::data_t                core_wdata,
	output cpu_pkg::data_t                core_rdata,
	input  logic                          ext_we,
	input  logic [$clog2(DMEM_DEPTH)-1:0] ext_addr,
	input  cpu_pkg::data_t                ext_wdata,
	output cpu_pkg::data_t                ext_rdata
);

	import cpu_pkg::*;

	localparam int ADDR_W = $clog2(DMEM_DEPTH);

	data_t             mem [DMEM_DEPTH];
	logic [ADDR_W-1:0] core_idx;

	// Core addresses wrap at the memory depth
	assign core_idx = core_addr[ADDR_W-1:0];

	always_ff @(posedge clk) begin
		if (run) begin
			if (ctl.memwr)
				mem[core_idx] <= core_wdata;
		end else if (ext_we) begin
			mem[ext_addr] <= ext_wdata;
		end
	end

	assign core_rdata = mem[core_idx];
	assign ext_rdata  = mem[ext_addr];

endmodule

// File: verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
	parameter int IMEM_DEPTH = 256,
	parameter int DMEM_DEPTH = 256
) (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          run,
	input  logic                          imem_we,
	input  logic [$clog2(IMEM_DEPTH)-1:0] imem_addr,
	input  cpu_pkg::instr_t               imem_wdata,
	input  logic                          dmem_we,
	input  logic [$clog2(DMEM_DEPTH)-1:0] dmem_addr,
	input  cpu_pkg::data_t                dmem_wdata,
	output cpu_pkg::data_t                dmem_rdata,
	output cpu_pkg::halt_reason_e         status,
	output logic [$clog2(IMEM_DEPTH)-1:0] pc
);

	import cpu_pkg::*;

	instr_t     instr;
	opcode_t    opcode;
	control_e   func;
	reg_idx_t   ra_idx;
	reg_idx_t   rb_idx;
	data_t      ra_data;
	data_t      rb_data;
	data_t      r0_data;
	data_t      alu_a;
	data_t      alu_b;
	data_t      alu_result;
	data_t      mem_rdata;
	data_t      wb_data;
	data_t      imm_ext;
	logic [3:0] imm_field;
	logic       alu_div0;
	logic       alu_ovf;
	logic       div0;
	logic       overflow;
	logic       illegal;
	logic       exception;
	logic       take_branch;
	logic       active;

	ctrl_if ctl ();

	assign opcode = opcode_t'(instr[15:12]);
	assign ra_idx = instr[11:8];
	assign rb_idx = instr[7:4];
	assign func   = control_e'(instr[3:0]);

	// Branch offsets overlap the func field, so flags only count for ARITHM
	assign div0      = alu_div0 && (opcode == ARITHM);
	assign overflow  = alu_ovf && (opcode == ARITHM);
	assign illegal   = instr[15:12] > 4'(HALT);
	assign exception = div0 || overflow || illegal;

	assign imm_field = (ctl.offset_sel == SEL_IMM_B) ? instr[7:4] : instr[3:0];
	assign imm_ext   = ctl.se_imm_a ? DATA_W'($signed(imm_field)) : DATA_W'(imm_field);

	// Loads and stores address from rb
	assign alu_a = ctl.alu_op ? rb_data : ra_data;

	always_comb begin
		case (ctl.offset_sel)
			SEL_IMM_B, SEL_IMM4: alu_b = imm_ext;
			default:             alu_b = rb_data;
		endcase
		if (ctl.r0_read)
			alu_b = r0_data;
	end

	always_comb begin
		case (opcode)
			BLT:     take_branch = $signed(ra_data) < $signed(r0_data);
			BGT:     take_branch = $signed(ra_data) > $signed(r0_data);
			BE:      take_branch = ra_data == r0_data;
			default: take_branch = 1'b0;
		endcase
	end

	assign wb_data = ctl.mem2r ? mem_rdata : alu_result;
	assign active  = run && (status == RUNNING);

	control_main u_control (
		.opcode   (opcode),
		.func     (func),
		.div0     (div0),
		.overflow (overflow),
		.ctl      (ctl.decoder)
	);

	alu u_alu (
		.a         (alu_a),
		.b         (alu_b),
		.func      (func),
		.force_add (ctl.alu_op),
		.result    (alu_result),
		.div0      (alu_div0),
		.overflow  (alu_ovf)
	);

	reg_file u_regs (
		.clk     (clk),
		.rst     (rst),
		.ra_idx  (ra_idx),
		.rb_idx  (rb_idx),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.r0_data (r0_data),
		.we      (ctl.reg_wr && active),
		.wr_idx  (ra_idx),
		.wr_data (wb_data)
	);

	fetch_unit #(
		.IMEM_DEPTH (IMEM_DEPTH)
	) u_fetch (
		.clk         (clk),
		.rst         (rst),
		.run         (run),
		.imem_we     (imem_we),
		.imem_addr   (imem_addr),
		.imem_wdata  (imem_wdata),
		.take_branch (take_branch),
		.ctl         (ctl.datapath),
		.exception   (exception),
		.instr       (instr),
		.pc          (pc),
		.status      (status)
	);

	data_mem #(
		.DMEM_DEPTH (DMEM_DEPTH)
	) u_dmem (
		.clk        (clk),
		.run        (run),
		.ctl        (ctl.datapath),
		.core_addr  (alu_result),
		.core_wdata (ra_data),
		.core_rdata (mem_rdata),
		.ext_we     (dmem_we),
		.ext_addr   (dmem_addr),
		.ext_wdata  (dmem_wdata),
		.ext_rdata  (dmem_rdata)
	);

endmodule

// File: test/cpu_asserts.sv
`timescale 1ns/1ps

module cpu_asserts #(
	parameter int PC_W = 8
) (
	input logic                  clk,
	input logic                  rst,
	input logic                  halt_sys,
	input logic                  reg_wr,
	input logic                  memwr,
	input cpu_pkg::halt_reason_e status,
	input logic [PC_W-1:0]       pc
);

	import cpu_pkg::*;

	// Decoder must block every write when it stops the core
	assert property (@(posedge clk) disable iff (rst) halt_sys |-> (!reg_wr && !memwr))
		else $error("write enable active while halt_sys is high");

	assert property (@(posedge clk) disable iff (rst) (status != RUNNING) |=> (status != RUNNING))
		else $error("status went back to RUNNING without reset");

	assert property (@(posedge clk) disable iff (rst) (status != RUNNING) |=> $stable(pc))
		else $error("pc moved after the core stopped");

endmodule

bind fetch_unit cpu_asserts #(
	.PC_W (PC_W)
) u_asserts (
	.clk      (clk),
	.rst      (rst),
	.halt_sys (ctl.halt_sys),
	.reg_wr   (ctl.reg_wr),
	.memwr    (ctl.memwr),
	.status   (status),
	.pc       (pc)
);

// File: test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb;

	import cpu_pkg::*;

	localparam int NUM_ROWS = 23;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * (12 + 40);

	logic         clk;
	logic         rst;
	logic         run;
	logic         imem_we;
	logic [7:0]   imem_addr;
	instr_t       imem_wdata;
	logic         dmem_we;
	logic [7:0]   dmem_addr;
	data_t        dmem_wdata;
	data_t        dmem_rdata;
	halt_reason_e status;
	logic [7:0]   pc;

	// One row per program with code, initial data and expected results
	string        row_name   [NUM_ROWS];
	instr_t       row_prog   [NUM_ROWS][8];
	data_t        row_data   [NUM_ROWS][4];
	halt_reason_e row_status [NUM_ROWS];
	int           row_pc     [NUM_ROWS];
	int           row_addr   [NUM_ROWS];
	data_t        row_word   [NUM_ROWS];
	int           n_rows;

	// Row under construction
	instr_t prog_buf [8];
	data_t  data_buf [4];

	logic [31:0] lcg_state;
	int          errors;
	int          checks;
	int          cycle_count;

	cpu_top DUT (
		.clk        (clk),
		.rst        (rst),
		.run        (run),
		.imem_we    (imem_we),
		.imem_addr  (imem_addr),
		.imem_wdata (imem_wdata),
		.dmem_we    (dmem_we),
		.dmem_addr  (dmem_addr),
		.dmem_wdata (dmem_wdata),
		.dmem_rdata (dmem_rdata),
		.status     (status),
		.pc         (pc)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("ERROR: run did not halt within %0d cycles", TIMEOUT_CYCLES);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	function automatic instr_t encode(input logic [3:0] op, input logic [3:0] ra,
			input logic [3:0] rb, input logic [3:0] low);
		return {op, ra, rb, low};
	endfunction

	function automatic data_t rand16();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16];
	endfunction

	// Expected ALU result with shift amounts taken modulo 16
	function automatic data_t ref_result(input control_e f, input data_t a, input data_t b);
		int s;
		s = b % 16;
		case (f)
			ADD: return a + b;
			SUB: return a - b;
			AND: return a & b;
			OR:  return a | b;
			XOR: return a ^ b;
			MUL: return a * b;
			DIV: return (b == 16'h0) ? 16'h0 : a / b;
			ROR: return (a >> s) | (a << (16 - s));
			ROL: return (a << s) | (a >> (16 - s));
			SHL: return a << s;
			SHR: return a >> s;
			default: return 16'h0;
		endcase
	endfunction

	function automatic logic ref_faults(input control_e f, input data_t a, input data_t b);
		int full;
		full = 0;
		case (f)
			ADD: full = $signed(a) + $signed(b);
			SUB: full = $signed(a) - $signed(b);
			DIV: return b == 16'h0;
			default: return 1'b0;
		endcase
		return (full > 32767) || (full < -32768);
	endfunction

	task automatic check_value(input string name, input string what,
			input logic [31:0] expected, input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h actual %h", name, what, expected, actual);
		end
	endtask

	task automatic add_row(input string name, input halt_reason_e st, input int exp_pc,
			input int addr, input data_t word);
		row_name[n_rows]   = name;
		row_status[n_rows] = st;
		row_pc[n_rows]     = exp_pc;
		row_addr[n_rows]   = addr;
		row_word[n_rows]   = word;
		for (int i = 0; i < 8; i++) begin
			row_prog[n_rows][i] = prog_buf[i];
			prog_buf[i] = encode(HALT, 4'd0, 4'd0, 4'd0);
		end
		for (int i = 0; i < 4; i++) begin
			row_data[n_rows][i] = data_buf[i];
			data_buf[i] = 16'h0;
		end
		n_rows++;
	endtask

	// r15 stays zero and serves as the load/store base
	task automatic add_arith_row(input string name, input control_e f,
			input data_t x, input data_t y);
		logic faults;
		faults = ref_faults(f, x, y);
		prog_buf[0] = encode(LW, 4'd1, 4'd15, 4'd0);
		prog_buf[1] = encode(LW, 4'd2, 4'd15, 4'd1);
		prog_buf[2] = encode(ARITHM, 4'd1, 4'd2, f);
		prog_buf[3] = encode(SW, 4'd1, 4'd15, 4'd2);
		data_buf = '{x, y, 16'hc3c3, 16'h0};
		add_row(name, faults ? EXCEPTION : HALTED, faults ? 2 : 4, 2,
			faults ? 16'hc3c3 : ref_result(f, x, y));
	endtask

	task automatic add_shift_row(input string name, input control_e f,
			input data_t x, input logic [3:0] amt);
		prog_buf[0] = encode(LW, 4'd1, 4'd15, 4'd0);
		prog_buf[1] = encode(ARITHM, 4'd1, amt, f);
		prog_buf[2] = encode(SW, 4'd1, 4'd15, 4'd2);
		data_buf = '{x, 16'h0, 16'hc3c3, 16'h0};
		add_row(name, HALTED, 3, 2, ref_result(f, x, amt));
	endtask

	// Taken path loads the marker at address 3, fall-through the one at address 2
	task automatic add_branch_row(input string name, input opcode_t op,
			input data_t r0v, input data_t rav);
		logic taken;
		case (op)
			BLT:     taken = $signed(rav) < $signed(r0v);
			BGT:     taken = $signed(rav) > $signed(r0v);
			default: taken = (rav == r0v);
		endcase
		prog_buf[0] = encode(LW, 4'd0, 4'd15, 4'd0);
		prog_buf[1] = encode(LW, 4'd1, 4'd15, 4'd1);
		prog_buf[2] = encode(op, 4'd1, 4'd0, 4'd3);
		prog_buf[3] = encode(LW, 4'd2, 4'd15, 4'd2);
		prog_buf[4] = encode(JMP, 4'd0, 4'd0, 4'd2);
		prog_buf[5] = encode(LW, 4'd2, 4'd15, 4'd3);
		prog_buf[6] = encode(SW, 4'd2, 4'd15, 4'd0);
		data_buf = '{r0v, rav, 16'h00aa, 16'h00bb};
		add_row(name, HALTED, 7, 0, taken ? 16'h00bb : 16'h00aa);
	endtask

	task automatic build_table();
		control_e arith_ops [7];
		control_e shift_ops [4];
		data_t    x;
		data_t    y;
		arith_ops = '{ADD, SUB, AND, OR, XOR, MUL, DIV};
		shift_ops = '{ROR, ROL, SHL, SHR};
		for (int i = 0; i < 8; i++)
			prog_buf[i] = encode(HALT, 4'd0, 4'd0, 4'd0);
		for (int i = 0; i < 7; i++) begin
			x = rand16();
			y = rand16();
			// Keep ADD and SUB operands in range so the result gets stored
			if ((arith_ops[i] == ADD) || (arith_ops[i] == SUB)) begin
				x = x & 16'h3fff;
				y = y & 16'h3fff;
			end
			add_arith_row(arith_ops[i].name(), arith_ops[i], x, y);
		end
		for (int i = 0; i < 4; i++) begin
			x = rand16();
			y = rand16();
			add_shift_row(shift_ops[i].name(), shift_ops[i], x, y[3:0]);
		end
		add_branch_row("blt_taken", BLT, 16'h0005, 16'hfffd);
		add_branch_row("blt_not_taken", BLT, 16'h0005, 16'h0007);
		add_branch_row("bgt_taken", BGT, 16'hfff0, 16'h0002);
		add_branch_row("bgt_not_taken", BGT, 16'h0003, 16'h8000);
		add_branch_row("be_taken", BE, 16'h1234, 16'h1234);
		add_branch_row("be_not_taken", BE, 16'h1234, 16'h1235);
		prog_buf[0] = encode(LW, 4'd1, 4'd15, 4'd0);
		prog_buf[1] = encode(JMP, 4'd0, 4'd0, 4'd2);
		prog_buf[2] = encode(SW, 4'd1, 4'd15, 4'd1);
		data_buf = '{16'h5a5a, 16'h1111, 16'h0, 16'h0};
		add_row("jmp_skip", HALTED, 3, 1, 16'h1111);
		add_arith_row("div_by_zero", DIV, 16'h1234, 16'h0000);
		add_arith_row("add_overflow", ADD, 16'h7fff, 16'h0001);
		add_arith_row("sub_overflow", SUB, 16'h8000, 16'h0001);
		// Opcode 10 shaped like a store to address 2
		prog_buf[0] = encode(LW, 4'd1, 4'd15, 4'd0);
		prog_buf[1] = 16'ha1f2;
		prog_buf[2] = encode(SW, 4'd1, 4'd15, 4'd2);
		data_buf = '{16'h4444, 16'h0, 16'hc3c3, 16'h0};
		add_row("illegal_opcode", EXCEPTION, 1, 2, 16'hc3c3);
		data_buf = '{16'h0f0f, 16'h0, 16'h0, 16'h0};
		add_row("plain_halt", HALTED, 0, 0, 16'h0f0f);
	endtask

	task automatic run_row(input int r);
		@(negedge clk);
		rst = 1'b1;
		run = 1'b0;
		repeat (4) @(negedge clk);
		rst = 1'b0;
		for (int i = 0; i < 4; i++) begin
			dmem_we    = 1'b1;
			dmem_addr  = 8'(i);
			dmem_wdata = row_data[r][i];
			@(negedge clk);
		end
		dmem_we = 1'b0;
		for (int i = 0; i < 8; i++) begin
			imem_we    = 1'b1;
			imem_addr  = 8'(i);
			imem_wdata = row_prog[r][i];
			@(negedge clk);
		end
		imem_we = 1'b0;
		run     = 1'b1;
		@(negedge clk);
		while (status == RUNNING)
			@(negedge clk);
		run = 1'b0;
		check_value(row_name[r], "status", row_status[r], status);
		check_value(row_name[r], "pc", row_pc[r], pc);
		dmem_addr = 8'(row_addr[r]);
		@(negedge clk);
		check_value(row_name[r], "data word", row_word[r], dmem_rdata);
	endtask

	initial begin
		rst         = 1'b1;
		run         = 1'b0;
		imem_we     = 1'b0;
		imem_addr   = 8'h0;
		imem_wdata  = 16'h0;
		dmem_we     = 1'b0;
		dmem_addr   = 8'h0;
		dmem_wdata  = 16'h0;
		lcg_state   = 32'h2fbb6b4f;
		errors      = 0;
		checks      = 0;
		cycle_count = 0;
		n_rows      = 0;
		build_table();
		for (int r = 0; r < n_rows; r++)
			run_row(r);
		$display("Summary: %0d rows, %0d checks, %0d errors", n_rows, checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: list.f
verilog/cpu_pkg.sv
verilog/ctrl_if.sv
verilog/control_main.sv
verilog/alu.sv
verilog/reg_file.sv
verilog/fetch_unit.sv
verilog/data_mem.sv
verilog/cpu_top.sv
test/cpu_asserts.sv
test/cpu_tb.sv
